// ==== build.f ====
+incdir+src
src/color_sensor_pkg.sv
src/i2c_txn_sequencer.sv
src/i2c_byte_fsm.sv
src/i2c_line_driver.sv
src/color_sensor_i2c.sv
verification/color_sensor_sva.sv
verification/color_sensor_checker.sv
verification/color_sensor_tb.sv

// ==== Bender.yml ====
package:
  name: color_sensor_i2c

sources:
  - include_dirs:
      - src
    files:
      - src/color_sensor_pkg.sv
      - src/i2c_txn_sequencer.sv
      - src/i2c_byte_fsm.sv
      - src/i2c_line_driver.sv
      - src/color_sensor_i2c.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/color_sensor_sva.sv
      - verification/color_sensor_checker.sv
      - verification/color_sensor_tb.sv

// ==== verification/color_sensor_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "color_sensor_consts.svh"

module color_sensor_tb;

	localparam int CYCLE_LIMIT = 2 * (3 * 116 + 9 * 164) + 1000;

	logic i2c_clk;
	logic sys_rst_n;
	logic i2c_start;
	logic [`CFG_DATA_W-1:0] cfg_data;
	logic quiet;
	logic quiet_end;
	wire [`CFG_NUM_W-1:0] cfg_num;
	wire cfg_start;
	wire [`COLOR_W-1:0] data_r;
	wire [`COLOR_W-1:0] data_g;
	wire [`COLOR_W-1:0] data_b;
	wire data_valid;
	wire scl;
	wire sda;

	logic [15:0] stim_table [0:`LAST_CFG_NUM];	// reg address, write data or sensor byte
	logic [31:0] seed;
	int cycle_cnt = 0;
	int total_errs;

	// sensor model state
	logic sensor_low = 1'b0;
	logic s_active = 1'b0;
	logic s_rd;
	int s_bit;
	int s_byte;
	logic [7:0] s_shreg;
	logic [7:0] s_reg;
	logic [7:0] s_tx;

	color_sensor_i2c i_color_sensor_i2c (
		.i2c_clk	(i2c_clk),
		.sys_rst_n	(sys_rst_n),
		.i2c_start	(i2c_start),
		.cfg_data	(cfg_data),
		.cfg_num	(cfg_num),
		.cfg_start	(cfg_start),
		.data_r		(data_r),
		.data_g		(data_g),
		.data_b		(data_b),
		.data_valid	(data_valid),
		.scl		(scl),
		.sda		(sda)
	);

	color_sensor_checker i_checker (
		.i2c_clk	(i2c_clk),
		.sys_rst_n	(sys_rst_n),
		.scl		(scl),
		.sda		(sda),
		.cfg_start	(cfg_start),
		.data_valid	(data_valid),
		.cfg_num	(cfg_num),
		.data_r		(data_r),
		.data_g		(data_g),
		.data_b		(data_b),
		.quiet		(quiet),
		.quiet_end	(quiet_end)
	);

	bind color_sensor_i2c color_sensor_sva i_sva (
		.i2c_clk	(i2c_clk),
		.sys_rst_n	(sys_rst_n),
		.scl		(scl),
		.sda		(sda),
		.cfg_start	(cfg_start),
		.data_valid	(data_valid),
		.cfg_num	(cfg_num),
		.state		(state)
	);

	pullup (sda);
	assign sda = sensor_low ? 1'b0 : 1'bz;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] sensor_byte(input logic [7:0] reg_addr);
		for (int i = `CFG_WRITES; i <= `LAST_CFG_NUM; i++) begin
			if (stim_table[i][15:8] == reg_addr) return stim_table[i][7:0];
		end
		return 8'hff;
	endfunction

	task automatic refill_sensor_bytes();
		for (int i = `CFG_WRITES; i <= `LAST_CFG_NUM; i++) begin
			seed = lcg_next(seed);
			stim_table[i] = {8'h10 + 8'(i), seed[23:16]};
		end
	endtask

	task automatic wait_cycles_until_valid();
		@(posedge i2c_clk);
		while (!data_valid) @(posedge i2c_clk);
	endtask

	always #5 i2c_clk = ~i2c_clk;

	always @(posedge i2c_clk) begin
		cfg_data <= stim_table[cfg_num];	// table row follows cfg_num
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	always @(negedge sda) begin
		if (sys_rst_n && (scl === 1'b1)) begin
			s_active = 1'b1;
			s_bit = 0;
			s_byte = 0;
			s_rd = 1'b0;
		end
	end

	always @(posedge sda) begin
		if (sys_rst_n && (scl === 1'b1)) s_active = 1'b0;
	end

	always @(posedge scl) begin
		if (s_active) begin
			if (s_bit < 8) begin
				s_shreg = {s_shreg[6:0], sda};
				s_bit++;
			end else begin
				s_bit = 0;
				s_byte++;
			end
		end
	end

	// slave changes sda only while scl is low
	always @(negedge scl) begin
		if (s_active) begin
			if (s_bit == 8) begin
				if (s_byte == 0) begin
					s_rd = s_shreg[0];
					sensor_low <= (s_shreg[7:1] == `SENSOR_ADDR);
				end else if (!s_rd) begin
					if (s_byte == 1) s_reg = s_shreg;
					sensor_low <= 1'b1;
				end else begin
					sensor_low <= 1'b0;	// master nacks the read byte
				end
			end else if (s_rd && (s_byte == 1)) begin
				if (s_bit == 0) s_tx = sensor_byte(s_reg);
				sensor_low <= !s_tx[7 - s_bit];
			end else begin
				sensor_low <= 1'b0;
			end
		end
	end

	initial begin
		i2c_clk = 1'b0;
		sys_rst_n = 1'b0;
		i2c_start = 1'b0;
		cfg_data = '0;
		quiet = 1'b0;
		quiet_end = 1'b0;
		seed = 32'hc4f86f36;
		stim_table[0] = {8'h00, 8'h03};
		stim_table[1] = {8'h04, 8'h22};
		stim_table[2] = {8'h05, 8'h41};
		for (int round = 0; round < 2; round++) begin
			refill_sensor_bytes();
			if (round == 0) begin
				repeat (16) @(posedge i2c_clk);
				sys_rst_n <= 1'b1;
				@(posedge i2c_clk);
				i2c_start <= 1'b1;
			end
			wait_cycles_until_valid();
			@(negedge i2c_clk);	// checker has sampled this round
		end
		// drop the enable inside the next transaction
		@(posedge i2c_clk);
		while (scl) @(posedge i2c_clk);
		i2c_start <= 1'b0;
		@(posedge i2c_clk);
		while (!cfg_start) @(posedge i2c_clk);
		quiet <= 1'b1;
		repeat (300) @(posedge i2c_clk);
		quiet_end <= 1'b1;
		@(posedge i2c_clk);
		quiet_end <= 1'b0;
		@(posedge i2c_clk);
		total_errs = i_checker.err_cnt + i_color_sensor_i2c.i_sva.sva_errs;
		$display("checks passed %0d, failed %0d, assertion failures %0d",
			i_checker.pass_cnt, i_checker.err_cnt, i_color_sensor_i2c.i_sva.sva_errs);
		if (total_errs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/color_sensor_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "color_sensor_consts.svh"

module color_sensor_checker (
	input  wire			i2c_clk,
	input  wire			sys_rst_n,
	input  wire			scl,
	input  wire			sda,
	input  wire			cfg_start,
	input  wire			data_valid,
	input  wire [`CFG_NUM_W-1:0]	cfg_num,
	input  wire [`COLOR_W-1:0]	data_r,
	input  wire [`COLOR_W-1:0]	data_g,
	input  wire [`COLOR_W-1:0]	data_b,
	input  wire			quiet,
	input  wire			quiet_end
);

	localparam logic [7:0] ADDR_WR = {`SENSOR_ADDR, 1'b0};
	localparam logic [7:0] ADDR_RD = {`SENSOR_ADDR, 1'b1};

	int pass_cnt = 0;
	int err_cnt = 0;
	int exp_num = 0;	// transaction number the next frame should carry
	int frame_cnt = 0;
	int frames_since_valid = 0;
	int round_cnt = 0;
	int quiet_starts = 0;
	int bit_cnt = 0;
	int nbytes = 0;
	int restart_at = -1;
	logic in_frame = 1'b0;
	logic reset_checked = 1'b0;
	logic [7:0] shreg;
	logic [7:0] bytes [0:7];
	logic acks [0:7];

	function automatic color_sensor_pkg::txn_kind_t kind_of(input int num);
		if (num < `CFG_WRITES) return color_sensor_pkg::TXN_CFG_WRITE;
		if (num < `CFG_WRITES + `REGS_PER_COLOR) return color_sensor_pkg::TXN_READ_G;
		if (num < `CFG_WRITES + 2 * `REGS_PER_COLOR) return color_sensor_pkg::TXN_READ_R;
		return color_sensor_pkg::TXN_READ_B;
	endfunction

	function automatic logic [`COLOR_W-1:0] channel_word(input int first);
		return {color_sensor_tb.stim_table[first][7:0],
			color_sensor_tb.stim_table[first + 1][7:0],
			color_sensor_tb.stim_table[first + 2][7:0]};
	endfunction

	task automatic check_frame();
		logic [15:0] row;
		logic ok;
		row = color_sensor_tb.stim_table[exp_num];
		ok = (color_sensor_tb.i_color_sensor_i2c.i_txn_sequencer.txn_kind == kind_of(exp_num));
		if (exp_num < `CFG_WRITES) begin
			ok = ok && (nbytes == 3) && (restart_at == -1) && (bytes[0] == ADDR_WR) &&
				(bytes[1] == row[15:8]) && (bytes[2] == row[7:0]) &&
				!acks[0] && !acks[1] && !acks[2];
		end else begin
			ok = ok && (nbytes == 4) && (restart_at == 2) && (bytes[0] == ADDR_WR) &&
				(bytes[1] == row[15:8]) && (bytes[2] == ADDR_RD) &&
				(bytes[3] == row[7:0]) && !acks[0] && !acks[1] && !acks[2] && acks[3];
		end
		if (ok) begin
			pass_cnt++;
			$display("frame %0d for cfg_num %0d ok", frame_cnt, exp_num);
		end else begin
			err_cnt++;
			$display("Error at %0t: frame %0d for cfg_num %0d has %0d bytes, first %h %h",
				$time, frame_cnt, exp_num, nbytes, bytes[0], bytes[1]);
		end
		frame_cnt++;
		frames_since_valid++;
		exp_num = (exp_num == `LAST_CFG_NUM) ? `CFG_WRITES : exp_num + 1;
	endtask

	always @(negedge sda) begin
		if (sys_rst_n && (scl === 1'b1)) begin
			if (quiet) begin
				quiet_starts++;
				err_cnt++;
				$display("a START appeared after i2c_start was dropped");
			end
			if (in_frame) begin
				restart_at = nbytes;	// repeated start
			end else begin
				nbytes = 0;
				restart_at = -1;
			end
			in_frame = 1'b1;
			bit_cnt = 0;
		end
	end

	always @(posedge sda) begin
		if (sys_rst_n && (scl === 1'b1) && in_frame) begin
			in_frame = 1'b0;
			check_frame();
		end
	end

	always @(posedge scl) begin
		if (in_frame) begin
			if (bit_cnt < 8) begin
				shreg = {shreg[6:0], sda};
				bit_cnt++;
			end else begin	// ack slot
				if (nbytes < 8) begin
					bytes[nbytes] = shreg;
					acks[nbytes] = sda;
				end
				nbytes++;
				bit_cnt = 0;
			end
		end
	end

	always @(posedge i2c_clk) begin
		if (sys_rst_n && !reset_checked) begin
			reset_checked = 1'b1;
			if ((scl === 1'b1) && (sda === 1'b1) && !cfg_start && !data_valid &&
					(cfg_num == 0)) begin
				pass_cnt++;
				$display("reset values ok");
			end else begin
				err_cnt++;
				$display("Error at %0t: wrong values after reset, scl %b sda %b num %0d",
					$time, scl, sda, cfg_num);
			end
		end
		if (data_valid) begin
			if ((data_g == channel_word(`CFG_WRITES)) &&
					(data_r == channel_word(`CFG_WRITES + `REGS_PER_COLOR)) &&
					(data_b == channel_word(`CFG_WRITES + 2 * `REGS_PER_COLOR)) &&
					(frames_since_valid == ((round_cnt == 0) ? 12 : 9))) begin
				pass_cnt++;
				$display("round %0d channel words ok", round_cnt);
			end else begin
				err_cnt++;
				$display("Error at %0t: round %0d g %h r %h b %h after %0d frames",
					$time, round_cnt, data_g, data_r, data_b, frames_since_valid);
			end
			round_cnt++;
			frames_since_valid = 0;
		end
		if (quiet_end) begin
			if (quiet_starts == 0) begin
				pass_cnt++;
				$display("bus idle after i2c_start dropped ok");
			end else begin
				err_cnt++;
				$display("Error at %0t: %0d START conditions after i2c_start dropped",
					$time, quiet_starts);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/color_sensor_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "color_sensor_consts.svh"

module color_sensor_sva (
	input  wire				i2c_clk,
	input  wire				sys_rst_n,
	input  wire				scl,
	input  wire				sda,
	input  wire				cfg_start,
	input  wire				data_valid,
	input  wire [`CFG_NUM_W-1:0]		cfg_num,
	input  wire color_sensor_pkg::bus_state_t	state
);

	int sva_errs = 0;	// read by the testbench at the end

	a_cfg_start_pulse: assert property (@(posedge i2c_clk) disable iff (!sys_rst_n)
		cfg_start |=> !cfg_start)
	else begin
		sva_errs++;
		$error("cfg_start held for more than one cycle");
	end

	// data may only change while scl is low
	a_sda_stable: assert property (@(posedge i2c_clk) disable iff (!sys_rst_n)
		(scl && $past(scl) && (state != color_sensor_pkg::ST_START) &&
		(state != color_sensor_pkg::ST_STOP)) |-> $stable(sda))
	else begin
		sva_errs++;
		$error("sda changed while scl was high");
	end

	a_wrap_to_green: assert property (@(posedge i2c_clk) disable iff (!sys_rst_n)
		data_valid |-> (cfg_num == `CFG_WRITES))
	else begin
		sva_errs++;
		$error("read loop did not restart at the first green register");
	end

endmodule

`default_nettype wire

// ==== src/color_sensor_i2c.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "color_sensor_consts.svh"

module color_sensor_i2c (
	input  wire			i2c_clk,
	input  wire			sys_rst_n,
	input  wire			i2c_start,
	input  wire [`CFG_DATA_W-1:0]	cfg_data,
	output wire [`CFG_NUM_W-1:0]	cfg_num,
	output wire			cfg_start,
	output wire [`COLOR_W-1:0]	data_r,
	output wire [`COLOR_W-1:0]	data_g,
	output wire [`COLOR_W-1:0]	data_b,
	output wire			data_valid,
	output wire			scl,
	inout  wire			sda
);

	wire color_sensor_pkg::bus_state_t state;
	wire [1:0] phase;
	wire tx_bit;
	wire rx_mode;
	wire sda_in;
	wire txn_go;
	wire txn_read;
	wire txn_done;
	wire rx_valid;
	wire [`BYTE_W-1:0] rx_byte;

	i2c_txn_sequencer i_txn_sequencer (
		.i2c_clk	(i2c_clk),
		.sys_rst_n	(sys_rst_n),
		.i2c_start	(i2c_start),
		.txn_done	(txn_done),
		.rx_valid	(rx_valid),
		.rx_byte	(rx_byte),
		.txn_go		(txn_go),
		.txn_read	(txn_read),
		.cfg_num	(cfg_num),
		.cfg_start	(cfg_start),
		.data_r		(data_r),
		.data_g		(data_g),
		.data_b		(data_b),
		.data_valid	(data_valid)
	);

	i2c_byte_fsm i_byte_fsm (
		.i2c_clk	(i2c_clk),
		.sys_rst_n	(sys_rst_n),
		.txn_go		(txn_go),
		.txn_read	(txn_read),
		.cfg_data	(cfg_data),
		.sda_in		(sda_in),
		.state		(state),
		.phase		(phase),
		.tx_bit		(tx_bit),
		.rx_mode	(rx_mode),
		.rx_byte	(rx_byte),
		.rx_valid	(rx_valid),
		.txn_done	(txn_done)
	);

	i2c_line_driver i_line_driver (
		.state		(state),
		.phase		(phase),
		.tx_bit		(tx_bit),
		.rx_mode	(rx_mode),
		.scl		(scl),
		.sda_in		(sda_in),
		.sda		(sda)
	);

endmodule

`default_nettype wire

// ==== src/i2c_line_driver.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_line_driver (
	input  wire color_sensor_pkg::bus_state_t	state,
	input  wire [1:0]				phase,
	input  wire					tx_bit,
	input  wire					rx_mode,
	output logic					scl,
	output wire					sda_in,
	inout  wire					sda
);

	logic sda_level;
	logic sda_release;

	always_comb begin
		case (state)
			color_sensor_pkg::ST_IDLE: scl = 1'b1;
			color_sensor_pkg::ST_START: scl = (phase != 2'd3);
			color_sensor_pkg::ST_STOP: scl = (phase != 2'd0);
			color_sensor_pkg::ST_RESTART_WAIT: scl = 1'b0;
			default: scl = (phase == 2'd1) || (phase == 2'd2);	// high in the middle quarters
		endcase
	end

	always_comb begin
		case (state)
			color_sensor_pkg::ST_START: sda_level = (phase < 2'd2);	// falls while scl high
			color_sensor_pkg::ST_STOP: sda_level = (phase >= 2'd2);	// rises while scl high
			color_sensor_pkg::ST_SLAVE_ADDR,
			color_sensor_pkg::ST_REG_ADDR,
			color_sensor_pkg::ST_DATA: sda_level = tx_bit;
			default: sda_level = 1'b1;	// idle, nack, restart wait
		endcase
	end

	assign sda_release = (state == color_sensor_pkg::ST_ACK_ADDR) ||
			(state == color_sensor_pkg::ST_ACK_REG) ||
			(state == color_sensor_pkg::ST_ACK_DATA) ||
			((state == color_sensor_pkg::ST_DATA) && rx_mode);

	// open drain, high comes from the pull-up
	assign sda = (!sda_release && !sda_level) ? 1'b0 : 1'bz;
	assign sda_in = sda;

endmodule

`default_nettype wire

// ==== src/i2c_byte_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "color_sensor_consts.svh"

module i2c_byte_fsm (
	input  wire				i2c_clk,
	input  wire				sys_rst_n,
	input  wire				txn_go,
	input  wire				txn_read,
	input  wire [`CFG_DATA_W-1:0]		cfg_data,
	input  wire				sda_in,
	output color_sensor_pkg::bus_state_t	state,
	output logic [1:0]			phase,
	output logic				tx_bit,
	output logic				rx_mode,
	output logic [`BYTE_W-1:0]		rx_byte,
	output logic				rx_valid,
	output logic				txn_done
);

	color_sensor_pkg::bus_state_t next_state;
	logic [2:0] bit_cnt;
	logic ack_seen;
	logic quarter_end;
	logic byte_end;
	logic ack_step;
	logic bit_state;
	logic ack_state;
	logic [`BYTE_W-1:0] addr_byte;
	logic [`BYTE_W-1:0] reg_addr;
	logic [`BYTE_W-1:0] wr_data;

	assign quarter_end = (phase == 2'd3);
	assign byte_end = quarter_end && (bit_cnt == 3'd7);
	assign ack_step = quarter_end && ack_seen;
	assign bit_state = (state == color_sensor_pkg::ST_SLAVE_ADDR) ||
			(state == color_sensor_pkg::ST_REG_ADDR) ||
			(state == color_sensor_pkg::ST_DATA);
	assign ack_state = (state == color_sensor_pkg::ST_ACK_ADDR) ||
			(state == color_sensor_pkg::ST_ACK_REG) ||
			(state == color_sensor_pkg::ST_ACK_DATA);

	always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= color_sensor_pkg::ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			color_sensor_pkg::ST_IDLE: begin
				if (txn_go) next_state = color_sensor_pkg::ST_START;
			end
			color_sensor_pkg::ST_START: begin
				if (quarter_end) next_state = color_sensor_pkg::ST_SLAVE_ADDR;
			end
			color_sensor_pkg::ST_SLAVE_ADDR: begin
				if (byte_end) next_state = color_sensor_pkg::ST_ACK_ADDR;
			end
			color_sensor_pkg::ST_ACK_ADDR: begin	// read address goes straight to data
				if (ack_step) begin
					next_state = rx_mode ? color_sensor_pkg::ST_DATA :
							color_sensor_pkg::ST_REG_ADDR;
				end
			end
			color_sensor_pkg::ST_REG_ADDR: begin
				if (byte_end) next_state = color_sensor_pkg::ST_ACK_REG;
			end
			color_sensor_pkg::ST_ACK_REG: begin
				if (ack_step) begin
					next_state = txn_read ? color_sensor_pkg::ST_RESTART_WAIT :
							color_sensor_pkg::ST_DATA;
				end
			end
			color_sensor_pkg::ST_DATA: begin
				if (byte_end) begin
					next_state = rx_mode ? color_sensor_pkg::ST_NACK :
							color_sensor_pkg::ST_ACK_DATA;
				end
			end
			color_sensor_pkg::ST_ACK_DATA: begin
				if (ack_step) next_state = color_sensor_pkg::ST_STOP;
			end
			color_sensor_pkg::ST_NACK: begin
				if (quarter_end) next_state = color_sensor_pkg::ST_STOP;
			end
			color_sensor_pkg::ST_RESTART_WAIT: begin
				if (quarter_end) next_state = color_sensor_pkg::ST_START;
			end
			color_sensor_pkg::ST_STOP: begin
				if (quarter_end) next_state = color_sensor_pkg::ST_IDLE;
			end
			default: next_state = color_sensor_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			phase <= 2'd0;
			bit_cnt <= 3'd0;
			ack_seen <= 1'b0;
			rx_mode <= 1'b0;
		end else begin
			if (state == color_sensor_pkg::ST_IDLE) begin
				phase <= 2'd0;
			end else begin
				phase <= phase + 2'd1;
			end
			if (!bit_state) begin
				bit_cnt <= 3'd0;
			end else if (quarter_end) begin
				bit_cnt <= bit_cnt + 3'd1;
			end
			if (ack_state && (phase == 2'd2)) begin
				ack_seen <= ~sda_in;	// slave holds sda low to acknowledge
			end
			if ((state == color_sensor_pkg::ST_RESTART_WAIT) && quarter_end) begin
				rx_mode <= 1'b1;
			end else if (txn_done) begin
				rx_mode <= 1'b0;
			end
		end
	end

	always_ff @(posedge i2c_clk) begin
		if (txn_go) begin
			reg_addr <= cfg_data[`CFG_DATA_W-1:`BYTE_W];
			wr_data <= cfg_data[`BYTE_W-1:0];
		end
	end

	// sample on the first high quarter of scl
	always_ff @(posedge i2c_clk) begin
		if ((state == color_sensor_pkg::ST_DATA) && rx_mode && (phase == 2'd1)) begin
			rx_byte <= {rx_byte[`BYTE_W-2:0], sda_in};
		end
	end

	assign addr_byte = {`SENSOR_ADDR, rx_mode};	// r/w bit

	always_comb begin
		case (state)
			color_sensor_pkg::ST_SLAVE_ADDR: tx_bit = addr_byte[3'd7 - bit_cnt];
			color_sensor_pkg::ST_REG_ADDR: tx_bit = reg_addr[3'd7 - bit_cnt];
			color_sensor_pkg::ST_DATA: tx_bit = wr_data[3'd7 - bit_cnt];
			default: tx_bit = 1'b1;
		endcase
	end

	assign rx_valid = (state == color_sensor_pkg::ST_DATA) && rx_mode && byte_end;
	assign txn_done = (state == color_sensor_pkg::ST_STOP) && quarter_end;

endmodule

`default_nettype wire

// ==== src/i2c_txn_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "color_sensor_consts.svh"

module i2c_txn_sequencer (
	input  wire			i2c_clk,
	input  wire			sys_rst_n,
	input  wire			i2c_start,
	input  wire			txn_done,
	input  wire			rx_valid,
	input  wire [`BYTE_W-1:0]	rx_byte,
	output logic			txn_go,
	output logic			txn_read,
	output logic [`CFG_NUM_W-1:0]	cfg_num,
	output logic			cfg_start,
	output logic [`COLOR_W-1:0]	data_r,
	output logic [`COLOR_W-1:0]	data_g,
	output logic [`COLOR_W-1:0]	data_b,
	output logic			data_valid
);

	localparam logic [`CFG_NUM_W-1:0] FIRST_READ = `CFG_WRITES;
	localparam logic [`CFG_NUM_W-1:0] FIRST_RED = `CFG_WRITES + `REGS_PER_COLOR;
	localparam logic [`CFG_NUM_W-1:0] FIRST_BLUE = `CFG_WRITES + 2 * `REGS_PER_COLOR;
	localparam logic [`CFG_NUM_W-1:0] LAST_NUM = `LAST_CFG_NUM;

	color_sensor_pkg::txn_kind_t txn_kind;
	logic txn_open;
	logic last_read;
	logic [`COLOR_W-1:0] shadow_g;
	logic [`COLOR_W-1:0] shadow_r;
	logic [`COLOR_W-1:0] shadow_b;

	always_comb begin
		if (cfg_num < FIRST_READ) begin
			txn_kind = color_sensor_pkg::TXN_CFG_WRITE;
		end else if (cfg_num < FIRST_RED) begin
			txn_kind = color_sensor_pkg::TXN_READ_G;
		end else if (cfg_num < FIRST_BLUE) begin
			txn_kind = color_sensor_pkg::TXN_READ_R;
		end else begin
			txn_kind = color_sensor_pkg::TXN_READ_B;
		end
	end

	assign txn_read = (txn_kind != color_sensor_pkg::TXN_CFG_WRITE);	// stable until txn_done
	assign last_read = (cfg_num == LAST_NUM);

	always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			txn_open <= 1'b0;
			txn_go <= 1'b0;
		end else begin
			txn_go <= i2c_start && !txn_open;	// single pulse, open flag blocks the next
			if (i2c_start && !txn_open) begin
				txn_open <= 1'b1;
			end else if (txn_done) begin
				txn_open <= 1'b0;
			end
		end
	end

	always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cfg_num <= '0;
			cfg_start <= 1'b0;
			data_valid <= 1'b0;
		end else begin
			cfg_start <= txn_done;
			data_valid <= txn_done && last_read;
			if (txn_done) begin
				cfg_num <= last_read ? FIRST_READ : cfg_num + 1'b1;	// config is done once
			end
		end
	end

	// first byte of a channel ends up on top
	always_ff @(posedge i2c_clk) begin
		if (rx_valid) begin
			case (txn_kind)
				color_sensor_pkg::TXN_READ_G: begin
					shadow_g <= {shadow_g[`COLOR_W-`BYTE_W-1:0], rx_byte};
				end
				color_sensor_pkg::TXN_READ_R: begin
					shadow_r <= {shadow_r[`COLOR_W-`BYTE_W-1:0], rx_byte};
				end
				color_sensor_pkg::TXN_READ_B: begin
					shadow_b <= {shadow_b[`COLOR_W-`BYTE_W-1:0], rx_byte};
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			data_r <= '0;
			data_g <= '0;
			data_b <= '0;
		end else if (txn_done && last_read) begin	// all three channels at once
			data_r <= shadow_r;
			data_g <= shadow_g;
			data_b <= shadow_b;
		end
	end

endmodule

`default_nettype wire

// ==== src/color_sensor_pkg.sv ====
`default_nettype none

package color_sensor_pkg;

	typedef enum logic [3:0] {
		ST_IDLE		= 4'd0,
		ST_START	= 4'd1,
		ST_SLAVE_ADDR	= 4'd2,
		ST_ACK_ADDR	= 4'd3,
		ST_REG_ADDR	= 4'd4,
		ST_ACK_REG	= 4'd5,
		ST_DATA		= 4'd6,
		ST_ACK_DATA	= 4'd7,
		ST_NACK		= 4'd8,
		ST_RESTART_WAIT	= 4'd9,	// scl held low before the repeated start
		ST_STOP		= 4'd10
	} bus_state_t;

	typedef enum logic [1:0] {
		TXN_CFG_WRITE	= 2'd0,
		TXN_READ_G	= 2'd1,
		TXN_READ_R	= 2'd2,
		TXN_READ_B	= 2'd3
	} txn_kind_t;

endpackage

`default_nettype wire

// ==== src/color_sensor_consts.svh ====
`ifndef COLOR_SENSOR_CONSTS_SVH
`define COLOR_SENSOR_CONSTS_SVH

// 7-bit bus address of the colour sensor
`define SENSOR_ADDR	7'h53

`define CFG_WRITES	3	// register writes before the first read
`define REGS_PER_COLOR	3	// one byte per register, MSB first
`define COLOR_W		24

`define CFG_NUM_W	4
`define CFG_DATA_W	16	// reg address high byte, write data low byte
`define BYTE_W		8

// last read of blue, after it the loop goes back to green
`define LAST_CFG_NUM	(`CFG_WRITES + 3 * `REGS_PER_COLOR - 1)

`endif
